// ==== all.f ====
verilog/classifier_pkg.sv
verilog/classifier_pio.sv
verilog/hash_table_mem.sv
verilog/classifier_lookup.sv
verilog/classifier_top.sv
sim/classifier_checker.sv
sim/tb_classifier.sv

// ==== run.sh ====
#!/bin/sh
# build the classifier testbench with Verilator, run it into sim.log and grep the result.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module tb_classifier -f all.f \
	-o tb_classifier \
	&& ./obj_dir/tb_classifier > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "ALL CHECKS PASSED" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== sim/tb_classifier.sv ====
module tb_classifier;

	localparam int ACK_LIMIT = 64; // cycles allowed for each edge of pio_ack.

	logic        clk = 1'b0;
	logic        clk_div = 1'b0;
	logic [1:0]  div_count = 2'd0;
	logic        reset;
	logic        reg_wr;
	logic        reg_rd;
	logic [31:0] reg_addr;
	logic [31:0] reg_din;
	logic        pio_ack;
	logic        pio_rvalid;
	logic [31:0] pio_rdata;
	logic        key_valid;
	logic [31:0] flow_key;
	logic [15:0] topic_key;
	logic        result_valid;
	logic        flow_hit;
	logic [6:0]  flow_class;
	logic        topic_hit;
	logic [15:0] topic_mask;
	int          error_count;
	int          pio_checks;
	int          lookup_checks;
	int          timeout_count;
	logic [31:0] flow_keys [0:7];  // keys that have an entry programmed for them.
	logic [15:0] topic_keys [0:7];

	always #5 clk = ~clk;

	// clk_div strobes high for one cycle out of every four.
	always @(negedge clk) begin
		div_count <= div_count + 2'd1;
		clk_div   <= (div_count == 2'd3);
	end

	classifier_top u_classifier_top (.*);

	classifier_checker u_checker (.*);

	// waits for pio_ack to rise and then to fall again.
	task automatic wait_ack();
		int n;
		n = 0;
		while (!pio_ack && n < ACK_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!pio_ack) begin
			$display("pio_ack did not rise within %0d cycles at %0t", ACK_LIMIT, $time);
			timeout_count++;
		end
		n = 0;
		while (pio_ack && n < ACK_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (pio_ack) begin
			$display("pio_ack did not fall within %0d cycles at %0t", ACK_LIMIT, $time);
			timeout_count++;
		end
	endtask

	// one read or write; bits the decoder ignores get random filler.
	task automatic pio_access(input logic is_write, input logic [1:0] sel,
		input logic [7:0] index, input logic [31:0] data);
		reg_addr = {18'($urandom), sel, 4'($urandom), index};
		reg_din  = data;
		reg_wr   = is_write;
		reg_rd   = !is_write;
		@(negedge clk);
		reg_wr = 1'b0; // single-cycle pulse, address stays put.
		reg_rd = 1'b0;
		wait_ack();
	endtask

	task automatic write_readback(input logic [1:0] sel);
		logic [7:0]  index;
		logic [31:0] data;
		index = 8'($urandom);
		data  = $urandom;
		pio_access(1'b1, sel, index, data);
		pio_access(1'b0, sel, index, 32'd0);
	endtask

	// builds keys whose fold lands on a chosen bucket, then stores a matching entry.
	task automatic program_entry(input int slot, input logic valid);
		logic [23:0] ftag;
		logic [7:0]  fidx;
		logic [7:0]  ttag;
		logic [7:0]  tidx;
		ftag = 24'($urandom);
		fidx = 8'($urandom);
		ttag = 8'($urandom);
		tidx = 8'($urandom);
		flow_keys[slot]  = {ftag, fidx ^ ftag[23:16] ^ ftag[15:8] ^ ftag[7:0]};
		topic_keys[slot] = {ttag, tidx ^ ttag};
		pio_access(1'b1, classifier_pkg::FLOW_TABLE_SEL, fidx, {valid, ftag, 7'($urandom)});
		pio_access(1'b1, classifier_pkg::TOPIC_TABLE_SEL, tidx,
			{valid, ttag, 7'd0, 16'($urandom)});
	endtask

	task automatic send_key(input logic [31:0] fkey, input logic [15:0] tkey);
		key_valid = 1'b1;
		flow_key  = fkey;
		topic_key = tkey;
		@(negedge clk);
		key_valid = 1'b0; // the next call raises it again in the same step.
	endtask

	// back-to-back keys: stored, tag flipped (same bucket) or random.
	task automatic send_burst(input int count);
		int k;
		int pick;
		int kind;
		for (k = 0; k < count; k++) begin
			pick = $urandom_range(0, 7);
			kind = $urandom_range(0, 2);
			if (kind == 0)
				send_key(flow_keys[pick], topic_keys[pick]);
			else if (kind == 1)
				send_key(flow_keys[pick] ^ 32'h0000_0101, topic_keys[pick] ^ 16'h0101);
			else
				send_key($urandom, 16'($urandom));
		end
	endtask

	function automatic logic [1:0] mapped_sel();
		return ($urandom_range(0, 1) == 0) ? classifier_pkg::FLOW_TABLE_SEL :
			classifier_pkg::TOPIC_TABLE_SEL;
	endfunction

	initial begin
		int seed;
		int op;
		int i;
		reset         = 1'b1;
		reg_wr        = 1'b0;
		reg_rd        = 1'b0;
		reg_addr      = '0;
		reg_din       = '0;
		key_valid     = 1'b0;
		flow_key      = '0;
		topic_key     = '0;
		timeout_count = 0;
		seed = $urandom(32'h39e0_06f5);
		repeat (10) @(negedge clk);
		reset = 1'b0;
		repeat (300) @(negedge clk); // the clear walk takes 256 cycles.
		for (i = 0; i < 8; i++) begin
			pio_access(1'b0, classifier_pkg::FLOW_TABLE_SEL, 8'($urandom), 32'd0);
			pio_access(1'b0, classifier_pkg::TOPIC_TABLE_SEL, 8'($urandom), 32'd0);
		end
		for (i = 0; i < 8; i++) begin
			write_readback(classifier_pkg::FLOW_TABLE_SEL);
			write_readback(classifier_pkg::TOPIC_TABLE_SEL);
		end
		pio_access(1'b0, 2'd0, 8'($urandom), 32'd0); // unmapped codes ack anyway.
		pio_access(1'b1, 2'd0, 8'($urandom), $urandom);
		pio_access(1'b0, 2'd3, 8'($urandom), 32'd0);
		pio_access(1'b1, 2'd3, 8'($urandom), $urandom);
		for (i = 0; i < 8; i++)
			program_entry(i, i != 7); // the last slot is left invalid.
		for (i = 0; i < 8; i++)
			send_key(flow_keys[i], topic_keys[i]);
		for (i = 0; i < 8; i++)
			send_key(flow_keys[i] ^ 32'h0000_0101, topic_keys[i] ^ 16'h0101);
		for (i = 0; i < 200; i++) begin
			op = $urandom_range(0, 4);
			case (op)
				0: pio_access(1'b1, mapped_sel(), 8'($urandom), $urandom);
				1: pio_access(1'b0, mapped_sel(), 8'($urandom), 32'd0);
				2: pio_access($urandom_range(0, 1) == 1, ($urandom_range(0, 1) == 1) ? 2'd3 : 2'd0,
					8'($urandom), $urandom);
				3: send_burst($urandom_range(1, 4));
				default: program_entry($urandom_range(0, 7), 1'b1);
			endcase
		end
		repeat (4) @(negedge clk); // let the last lookups drain.
		$display("pio checks %0d, lookup checks %0d, errors %0d, timeouts %0d",
			pio_checks, lookup_checks, error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== sim/classifier_checker.sv ====
module classifier_checker (
	input  logic        clk,
	input  logic        reset,
	input  logic        reg_wr,
	input  logic        reg_rd,
	input  logic [31:0] reg_addr,
	input  logic [31:0] reg_din,
	input  logic        pio_ack,
	input  logic        pio_rvalid,
	input  logic [31:0] pio_rdata,
	input  logic        key_valid,
	input  logic [31:0] flow_key,
	input  logic [15:0] topic_key,
	input  logic        result_valid,
	input  logic        flow_hit,
	input  logic [6:0]  flow_class,
	input  logic        topic_hit,
	input  logic [15:0] topic_mask,
	output int          error_count,
	output int          pio_checks,
	output int          lookup_checks
);

	logic [31:0] flow_shadow [0:255];  // every word the host wrote to the flow table.
	logic [31:0] topic_shadow [0:255]; // same for the topic table.

	int          cycle;      // counts rising edges since reset.
	int          pio_issued; // accesses seen on the bus.
	int          pio_done;   // accesses whose ack has been checked.
	logic [31:0] exp_rdata;  // what pio_rdata must show when the ack rises.
	logic        exp_rvalid;
	logic        ack_prev;   // pio_ack at the previous falling edge.
	logic [1:0]  sel;
	logic [7:0]  idx;

	// lookups in flight, as {flow_hit, flow_class, topic_hit, topic_mask}.
	logic [24:0] exp_result [0:15];
	int          due_cycle [0:15];
	logic [3:0]  wr_ptr;
	logic [3:0]  rd_ptr;

	// each key folds its bytes down to one bucket index.
	function automatic logic [7:0] flow_hash(input logic [31:0] key);
		return key[31:24] ^ key[23:16] ^ key[15:8] ^ key[7:0];
	endfunction

	function automatic logic [7:0] topic_hash(input logic [15:0] key);
		return key[15:8] ^ key[7:0];
	endfunction

	// a hit needs bit 31 set and the stored tag equal to the upper key bits.
	function automatic logic [24:0] expected_lookup(input logic [31:0] fkey,
		input logic [15:0] tkey);
		logic [31:0] fword;
		logic [31:0] tword;
		logic        fhit;
		logic        thit;
		fword = flow_shadow[flow_hash(fkey)];
		tword = topic_shadow[topic_hash(tkey)];
		fhit  = fword[31] && (fword[30:7] == fkey[31:8]);    // 24-bit flow tag.
		thit  = tword[31] && (tword[30:23] == tkey[15:8]);   // 8-bit topic tag.
		return {fhit, fhit ? fword[6:0] : 7'd0, thit, thit ? tword[15:0] : 16'd0};
	endfunction

	task automatic check_field(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		if (got !== exp) begin
			$display("error at %0t: %s expected %0h got %0h", $time, name, exp, got);
			error_count++;
		end
	endtask

	// inputs are driven on the falling edge, so they are steady here.
	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 256; i++) begin
				flow_shadow[i]  = '0; // the clear walk zeroes every word.
				topic_shadow[i] = '0;
			end
			cycle      = 0;
			pio_issued = 0;
			wr_ptr     = '0;
		end else begin
			cycle++;
			// the lookup reads the table before a write of this edge lands.
			if (key_valid) begin
				exp_result[wr_ptr] = expected_lookup(flow_key, topic_key);
				due_cycle[wr_ptr]  = cycle + 1; // falling edge two cycles after the key.
				wr_ptr++;
			end
			if (reg_rd || reg_wr) begin
				sel        = reg_addr[classifier_pkg::MEM_SEL_LSB +: 2];
				idx        = reg_addr[7:0];
				exp_rvalid = (sel == classifier_pkg::FLOW_TABLE_SEL) ||
					(sel == classifier_pkg::TOPIC_TABLE_SEL);
				if (!exp_rvalid)
					exp_rdata = '0;          // unmapped codes read as zero.
				else if (reg_wr)
					exp_rdata = reg_din;     // a write echoes the new word.
				else if (sel == classifier_pkg::FLOW_TABLE_SEL)
					exp_rdata = flow_shadow[idx];
				else
					exp_rdata = topic_shadow[idx];
				if (reg_wr && sel == classifier_pkg::FLOW_TABLE_SEL)
					flow_shadow[idx] = reg_din;
				if (reg_wr && sel == classifier_pkg::TOPIC_TABLE_SEL)
					topic_shadow[idx] = reg_din;
				pio_issued++;
			end
		end
	end

	// outputs move on the rising edge, so the falling edge sees them settled.
	always @(negedge clk) begin
		if (reset) begin
			error_count   = 0;
			pio_checks    = 0;
			lookup_checks = 0;
			pio_done      = 0;
			ack_prev      = 1'b0;
			rd_ptr        = '0;
		end else begin
			if (pio_ack && !ack_prev) begin
				if (pio_done == pio_issued) begin
					$display("pio_ack rose at %0t with no access outstanding", $time);
					error_count++;
				end else begin
					check_field("pio_rdata", exp_rdata, pio_rdata);
					check_field("pio_rvalid", 32'(exp_rvalid), 32'(pio_rvalid));
					pio_done = pio_issued;
					pio_checks++;
				end
			end
			ack_prev = pio_ack;
			if (rd_ptr != wr_ptr && due_cycle[rd_ptr] <= cycle) begin
				if (!result_valid || due_cycle[rd_ptr] != cycle) begin
					$display("no lookup result at %0t two cycles after its key", $time);
					error_count++;
				end else begin
					check_field("flow_hit", 32'(exp_result[rd_ptr][24]), 32'(flow_hit));
					check_field("flow_class", 32'(exp_result[rd_ptr][23:17]), 32'(flow_class));
					check_field("topic_hit", 32'(exp_result[rd_ptr][16]), 32'(topic_hit));
					check_field("topic_mask", 32'(exp_result[rd_ptr][15:0]), 32'(topic_mask));
					lookup_checks++;
				end
				rd_ptr++;
			end else if (result_valid) begin
				$display("result_valid high at %0t without a key two cycles before", $time);
				error_count++;
			end
		end
	end

endmodule

// ==== verilog/classifier_top.sv ====
module classifier_top (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 clk_div,
	input  logic                                 reg_wr,
	input  logic                                 reg_rd,
	input  logic [classifier_pkg::PIO_NBITS-1:0] reg_addr,
	input  logic [classifier_pkg::PIO_NBITS-1:0] reg_din,
	output logic                                 pio_ack,
	output logic                                 pio_rvalid,
	output logic [classifier_pkg::PIO_NBITS-1:0] pio_rdata,
	input  logic                                 key_valid,
	input  logic [31:0]                          flow_key,
	input  logic [15:0]                          topic_key,
	output logic                                 result_valid,
	output logic                                 flow_hit,
	output logic [6:0]                           flow_class,
	output logic                                 topic_hit,
	output logic [15:0]                          topic_mask
);

	// table selects from the decoder.
	logic reg_ms_flow_hash_table;
	logic reg_ms_topic_hash_table;

	// PIO return path of each table.
	logic                                 flow_hash_table_mem_ack;
	logic [classifier_pkg::PIO_NBITS-1:0] flow_hash_table_mem_rdata;
	logic                                 topic_hash_table_mem_ack;
	logic [classifier_pkg::PIO_NBITS-1:0] topic_hash_table_mem_rdata;

	// lookup side of each table.
	logic [classifier_pkg::INDEX_BITS-1:0] flow_index;
	logic [classifier_pkg::PIO_NBITS-1:0]  flow_lookup_rdata;
	logic [classifier_pkg::INDEX_BITS-1:0] topic_index;
	logic [classifier_pkg::PIO_NBITS-1:0]  topic_lookup_rdata;

	classifier_pio u_classifier_pio (
		.clk                        (clk),
		.reset                      (reset),
		.clk_div                    (clk_div),
		.reg_wr                     (reg_wr),
		.reg_rd                     (reg_rd),
		.reg_addr                   (reg_addr),
		.flow_hash_table_mem_ack    (flow_hash_table_mem_ack),
		.flow_hash_table_mem_rdata  (flow_hash_table_mem_rdata),
		.topic_hash_table_mem_ack   (topic_hash_table_mem_ack),
		.topic_hash_table_mem_rdata (topic_hash_table_mem_rdata),
		.reg_ms_flow_hash_table     (reg_ms_flow_hash_table),
		.reg_ms_topic_hash_table    (reg_ms_topic_hash_table),
		.pio_ack                    (pio_ack),
		.pio_rvalid                 (pio_rvalid),
		.pio_rdata                  (pio_rdata)
	);

	// both tables see the whole bus, only the selected one answers.
	// the word index is the low byte of the address.
	hash_table_mem u_flow_table (
		.clk          (clk),
		.reset        (reset),
		.clk_div      (clk_div),
		.reg_ms       (reg_ms_flow_hash_table),
		.reg_wr       (reg_wr),
		.reg_rd       (reg_rd),
		.reg_addr     (reg_addr[classifier_pkg::INDEX_BITS-1:0]),
		.reg_din      (reg_din),
		.mem_ack      (flow_hash_table_mem_ack),
		.mem_rdata    (flow_hash_table_mem_rdata),
		.lookup_index (flow_index),
		.lookup_rdata (flow_lookup_rdata)
	);

	hash_table_mem u_topic_table (
		.clk          (clk),
		.reset        (reset),
		.clk_div      (clk_div),
		.reg_ms       (reg_ms_topic_hash_table),
		.reg_wr       (reg_wr),
		.reg_rd       (reg_rd),
		.reg_addr     (reg_addr[classifier_pkg::INDEX_BITS-1:0]),
		.reg_din      (reg_din),
		.mem_ack      (topic_hash_table_mem_ack),
		.mem_rdata    (topic_hash_table_mem_rdata),
		.lookup_index (topic_index),
		.lookup_rdata (topic_lookup_rdata)
	);

	classifier_lookup u_classifier_lookup (
		.clk          (clk),
		.reset        (reset),
		.key_valid    (key_valid),
		.flow_key     (flow_key),
		.topic_key    (topic_key),
		.flow_index   (flow_index),
		.flow_rdata   (flow_lookup_rdata),
		.topic_index  (topic_index),
		.topic_rdata  (topic_lookup_rdata),
		.result_valid (result_valid),
		.flow_hit     (flow_hit),
		.flow_class   (flow_class),
		.topic_hit    (topic_hit),
		.topic_mask   (topic_mask)
	);

endmodule

// ==== verilog/classifier_lookup.sv ====
module classifier_lookup (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic                                  key_valid,
	input  logic [31:0]                           flow_key,
	input  logic [15:0]                           topic_key,
	output logic [classifier_pkg::INDEX_BITS-1:0] flow_index,
	input  logic [classifier_pkg::PIO_NBITS-1:0]  flow_rdata,
	output logic [classifier_pkg::INDEX_BITS-1:0] topic_index,
	input  logic [classifier_pkg::PIO_NBITS-1:0]  topic_rdata,
	output logic                                  result_valid,
	output logic                                  flow_hit,
	output logic [6:0]                            flow_class,
	output logic                                  topic_hit,
	output logic [15:0]                           topic_mask
);

	// stage 1 state, riding next to the table read.
	logic        s1_valid;     // a key entered on the previous cycle.
	logic [23:0] s1_flow_tag;  // flow key bits 31..8.
	logic [7:0]  s1_topic_tag; // topic key bits 15..8.

	// table words seen through the shared union.
	classifier_pkg::hash_entry_u flow_entry;
	classifier_pkg::hash_entry_u topic_entry;

	logic flow_match;  // stage 2 compare result for the flow table.
	logic topic_match; // stage 2 compare result for the topic table.

	// the hash is an xor fold of the key bytes.
	// the index goes straight to the tables, whose lookup port registers it,
	// so the read is issued in the same cycle the key arrives.
	assign flow_index  = flow_key[31:24] ^ flow_key[23:16] ^ flow_key[15:8] ^ flow_key[7:0];
	assign topic_index = topic_key[15:8] ^ topic_key[7:0];

	// the tags are captured alongside so they line up with the returned word.
	always_ff @(posedge clk) begin
		s1_flow_tag  <= flow_key[31:8];
		s1_topic_tag <= topic_key[15:8];
	end

	assign flow_entry  = flow_rdata;  // only the flow view is read from here.
	assign topic_entry = topic_rdata; // and only the topic view from here.

	// a bucket holds one entry, so a hit needs the valid flag and an exact tag.
	assign flow_match = flow_entry.flow.valid &&
		(flow_entry.flow.tag == s1_flow_tag);
	assign topic_match = topic_entry.topic.valid &&
		(topic_entry.topic.tag == s1_topic_tag);

	// stage 2 registers the compare. results carry no reset since they only
	// mean something while result_valid is high.
	always_ff @(posedge clk) begin
		flow_hit  <= flow_match;
		topic_hit <= topic_match;
		// a miss reports zeros rather than whatever the bucket holds.
		flow_class <= flow_match ? flow_entry.flow.class_id : 7'd0;
		topic_mask <= topic_match ? topic_entry.topic.mask : 16'd0;
	end

	// the valid bit travels down the pipe with no stall, one key per cycle.
	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid     <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			s1_valid     <= key_valid; // table read in flight.
			result_valid <= s1_valid;  // compare done.
		end
	end

	// a live key must land on words the clear walk has already defined.
	a_lookup_word_known : assert property (@(posedge clk) disable iff (reset)
		s1_valid |-> !$isunknown({flow_rdata, topic_rdata}));

endmodule

// ==== verilog/hash_table_mem.sv ====
module hash_table_mem (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic                                  clk_div,
	input  logic                                  reg_ms,
	input  logic                                  reg_wr,
	input  logic                                  reg_rd,
	input  logic [classifier_pkg::INDEX_BITS-1:0] reg_addr,
	input  logic [classifier_pkg::PIO_NBITS-1:0]  reg_din,
	output logic                                  mem_ack,
	output logic [classifier_pkg::PIO_NBITS-1:0]  mem_rdata,
	input  logic [classifier_pkg::INDEX_BITS-1:0] lookup_index,
	output logic [classifier_pkg::PIO_NBITS-1:0]  lookup_rdata
);

	localparam int DEPTH = 1 << classifier_pkg::INDEX_BITS; // 256 buckets.

	// storage is kept as the shared table word, the lookup side picks the view.
	classifier_pkg::hash_entry_u mem [0:DEPTH-1];

	logic [classifier_pkg::INDEX_BITS-1:0] clear_index; // next word to zero.
	logic                                  clearing;    // clear walk still running.
	logic                                  access;      // PIO access accepted this cycle.

	// the host may only start an access when this table is selected.
	// accesses during the clear walk are not taken and get no ack.
	assign access = reg_ms && (reg_rd || reg_wr) && !clearing;

	// control state: the clear sequencer and the ack level.
	always_ff @(posedge clk) begin
		if (reset) begin
			clear_index <= '0;
			clearing    <= 1'b1; // start the walk as soon as reset drops.
			mem_ack     <= 1'b0;
		end else begin
			if (clearing) begin
				clear_index <= clear_index + 1'b1;
				if (clear_index == '1)
					clearing <= 1'b0; // last word is zeroed this cycle.
			end
			// the ack rises the cycle after the pulse and holds until the
			// next clk_div strobe, where the decoder has sampled it.
			if (access)
				mem_ack <= 1'b1;
			else if (clk_div)
				mem_ack <= 1'b0;
		end
	end

	// write port, shared by the clear walk and PIO writes.
	// the walk owns the array while it runs.
	always_ff @(posedge clk) begin
		if (clearing)
			mem[clear_index].raw <= '0;
		else if (access && reg_wr)
			mem[reg_addr].raw <= reg_din;
	end

	// PIO read data is held until the next access, a write returns the new word.
	always_ff @(posedge clk) begin
		if (access) begin
			if (reg_wr)
				mem_rdata <= reg_din;
			else
				mem_rdata <= mem[reg_addr].raw;
		end
	end

	// lookup port, one cycle from index to data and no enable.
	// a lookup racing a PIO write to the same word sees the old contents.
	always_ff @(posedge clk) begin
		lookup_rdata <= mem[lookup_index].raw;
	end

	// the host pulses one strobe at a time, whichever table it targets.
	a_rd_wr_exclusive : assert property (@(posedge clk) disable iff (reset)
		!(reg_rd && reg_wr));

endmodule

// ==== verilog/classifier_pio.sv ====
module classifier_pio (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 clk_div,
	input  logic                                 reg_wr,
	input  logic                                 reg_rd,
	input  logic [classifier_pkg::PIO_NBITS-1:0] reg_addr,
	input  logic                                 flow_hash_table_mem_ack,
	input  logic [classifier_pkg::PIO_NBITS-1:0] flow_hash_table_mem_rdata,
	input  logic                                 topic_hash_table_mem_ack,
	input  logic [classifier_pkg::PIO_NBITS-1:0] topic_hash_table_mem_rdata,
	output logic                                 reg_ms_flow_hash_table,
	output logic                                 reg_ms_topic_hash_table,
	output logic                                 pio_ack,
	output logic                                 pio_rvalid,
	output logic [classifier_pkg::PIO_NBITS-1:0] pio_rdata
);

	logic [1:0] table_sel;     // select field taken from the address.
	logic       n_pio_ack;     // ack of whatever the address points at.
	logic       n_pio_rvalid;  // high when the address maps to a table.
	logic       none_pending;  // an access was seen and no strobe has passed yet.
	logic       none_ack;      // fallback acknowledge for unmapped addresses.

	assign table_sel = reg_addr[classifier_pkg::MEM_SEL_LSB +: 2];

	// the decode is purely combinational, so the table select follows the
	// address and is already valid on the cycle the rd or wr pulse arrives.
	always_comb begin
		n_pio_ack               = none_ack; // unmapped codes fall back to the timer.
		n_pio_rvalid            = 1'b0;
		pio_rdata               = '0;       // unmapped reads return zero.
		reg_ms_flow_hash_table  = 1'b0;
		reg_ms_topic_hash_table = 1'b0;
		case (table_sel)
			classifier_pkg::FLOW_TABLE_SEL: begin
				n_pio_ack              = flow_hash_table_mem_ack;
				n_pio_rvalid           = 1'b1;
				pio_rdata              = flow_hash_table_mem_rdata;
				reg_ms_flow_hash_table = 1'b1;
			end
			classifier_pkg::TOPIC_TABLE_SEL: begin
				n_pio_ack               = topic_hash_table_mem_ack;
				n_pio_rvalid            = 1'b1;
				pio_rdata               = topic_hash_table_mem_rdata;
				reg_ms_topic_hash_table = 1'b1;
			end
			default: begin
				n_pio_ack = none_ack;
			end
		endcase
	end

	// ack and rvalid only move on clk_div strobes, so the host sees them
	// in the slow clock domain and each stays up for one full strobe period.
	always_ff @(posedge clk) begin
		if (reset) begin
			pio_ack      <= 1'b0;
			pio_rvalid   <= 1'b0;
			none_pending <= 1'b0;
			none_ack     <= 1'b0;
		end else begin
			if (clk_div) begin
				pio_ack    <= n_pio_ack;    // sample the selected ack on the strobe.
				pio_rvalid <= n_pio_rvalid; // rvalid moves together with it.
			end
			// a new pulse wins over the strobe so it is never lost.
			if (reg_rd || reg_wr)
				none_pending <= 1'b1;
			else if (clk_div)
				none_pending <= 1'b0;
			if (clk_div)
				none_ack <= none_pending; // one strobe of delay before it acks.
		end
	end

	// the table ack and the fallback flag both drop on the strobe that raised
	// pio_ack, so the ack is gone again after one strobe period.
	a_ack_one_period : assert property (@(posedge clk) disable iff (reset)
		clk_div && pio_ack |=> !pio_ack);

endmodule

// ==== verilog/classifier_pkg.sv ====
package classifier_pkg;

	// the PIO bus carries 32-bit addresses and 32-bit data words.
	localparam int PIO_NBITS = 32;

	// address bits 13 and 12 choose the table, the rest of the upper bits are ignored.
	localparam int MEM_SEL_LSB = 12;

	localparam logic [1:0] FLOW_TABLE_SEL  = 2'd1; // flow hash table.
	localparam logic [1:0] TOPIC_TABLE_SEL = 2'd2; // topic hash table.
	// codes 0 and 3 decode to nothing and are answered by the fallback timer.

	// both tables hold 256 words, addressed by bits 7 down to 0.
	// the xor fold of the keys produces exactly this many buckets.
	localparam int INDEX_BITS = 8;

	// flow view of a table word.
	// the tag is the upper 24 bits of the flow key, since the low byte
	// is already implied by the bucket it lands in.
	typedef struct packed {
		logic        valid;    // entry is in use.
		logic [23:0] tag;      // flow key bits 31..8.
		logic [6:0]  class_id; // class reported on a hit.
	} flow_entry_t;

	// topic view of a table word.
	// a topic key is only 16 bits, so one byte of tag is enough.
	typedef struct packed {
		logic        valid;    // entry is in use.
		logic [7:0]  tag;      // topic key bits 15..8.
		logic [6:0]  reserved; // written as zero by the host.
		logic [15:0] mask;     // subscriber mask reported on a hit.
	} topic_entry_t;

	// one 32-bit table word seen either as a flow entry, a topic entry or raw bits.
	// the valid flag sits at bit 31 in both views.
	typedef union packed {
		flow_entry_t  flow;
		topic_entry_t topic;
		logic [31:0]  raw;
	} hash_entry_u;

endpackage
